//--- hdl/mipsPkg.sv
package mipsPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    localparam logic [xlen-1:0] resetPc = 32'hbfc00000;

    // major opcodes in instr[31:26]
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // special funct field in instr[5:0]
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluLui
    } aluOpE;

    // youngest stage holding the operand
    typedef enum logic [1:0] {
        fwdRegFile, fwdExe, fwdMem, fwdWb
    } fwdSelE;

    typedef struct packed {
        aluOpE aluOp;
        logic  useImm;     // srcB from immediate
        logic  signExt;    // else zero extend
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  isBranch;
        logic  branchOnNe; // bne
        logic  destIsRt;   // i-type writes rt
        logic  legal;
    } ctrlS;

endpackage

//--- hdl/wbIf.sv
`timescale 1ns/1ps

interface wbIf import mipsPkg::*; ();

    logic                valid;    // committing this cycle
    logic                regWrite;
    logic [regAddrW-1:0] dest;
    logic [xlen-1:0]     data;
    logic [xlen-1:0]     pc;

    modport source (output valid, regWrite, dest, data, pc);

    modport regWr (input valid, regWrite, dest, data);

    // forwarding only needs to know who is writing where
    modport fwd (input valid, regWrite, dest);

endinterface

//--- hdl/mipsDecoder.sv
`timescale 1ns/1ps

module mipsDecoder import mipsPkg::*; (
    input  logic [xlen-1:0] instr_i,
    output ctrlS            ctrl_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    always_comb begin
        ctrl_o       = '0;  // unknown encodings fall through as a no-op
        ctrl_o.aluOp = aluAdd;
        case (opcode)
            opSpecial: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.legal    = 1'b1;
                case (funct)
                    fnAddu:  ctrl_o.aluOp = aluAdd;
                    fnSubu:  ctrl_o.aluOp = aluSub;
                    fnAnd:   ctrl_o.aluOp = aluAnd;
                    fnOr:    ctrl_o.aluOp = aluOr;
                    fnXor:   ctrl_o.aluOp = aluXor;
                    fnSlt:   ctrl_o.aluOp = aluSlt;
                    default: begin
                        ctrl_o.regWrite = 1'b0;
                        ctrl_o.legal    = 1'b0;
                    end
                endcase
            end
            opAddiu, opOri, opLui: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.destIsRt = 1'b1;
                ctrl_o.legal    = 1'b1;
                ctrl_o.signExt  = (opcode == opAddiu);  // ori and lui zero extend
                ctrl_o.aluOp    = (opcode == opAddiu) ? aluAdd :
                                  (opcode == opOri)   ? aluOr  : aluLui;
            end
            opLw, opSw: begin
                ctrl_o.useImm   = 1'b1;  // base + offset
                ctrl_o.signExt  = 1'b1;
                ctrl_o.legal    = 1'b1;
                ctrl_o.memRead  = (opcode == opLw);
                ctrl_o.memWrite = (opcode == opSw);
                ctrl_o.regWrite = (opcode == opLw);
                ctrl_o.destIsRt = 1'b1;
            end
            opBeq, opBne: begin
                ctrl_o.isBranch   = 1'b1;
                ctrl_o.branchOnNe = (opcode == opBne);
                ctrl_o.signExt    = 1'b1;  // word offset is signed
                ctrl_o.legal      = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic [regAddrW-1:0] raddrA_i,
    input  logic [regAddrW-1:0] raddrB_i,
    output logic [xlen-1:0]     rdataA_o,
    output logic [xlen-1:0]     rdataB_o,
    wbIf.regWr                  wb
);

    logic [xlen-1:0] regs [1:31];  // $0 is not stored
    logic            wrEn;

    assign wrEn = wb.valid & wb.regWrite & (wb.dest != '0);

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // same-cycle write shows up on the read side
    always_comb begin
        rdataA_o = (raddrA_i == '0) ? '0 : regs[raddrA_i];
        rdataB_o = (raddrB_i == '0) ? '0 : regs[raddrB_i];
        if (wrEn && wb.dest == raddrA_i) rdataA_o = wb.data;
        if (wrEn && wb.dest == raddrB_i) rdataB_o = wb.data;
    end

endmodule

//--- hdl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
    input  logic [regAddrW-1:0] rsD_i,
    input  logic [regAddrW-1:0] rtD_i,
    input  logic [regAddrW-1:0] destE_i,
    input  logic                regWriteE_i,
    input  logic                memReadE_i,
    input  logic [regAddrW-1:0] destM_i,
    input  logic                regWriteM_i,
    input  logic                memReadM_i,
    wbIf.fwd                    wb,
    input  logic                dataStall_i,
    output fwdSelE              fwdA_o,
    output fwdSelE              fwdB_o,
    output logic                stallFD_o,
    output logic                bubbleE_o,
    output logic                freeze_o
);

    logic writesE;
    logic writesM;
    logic writesW;
    logic loadUse;

    // $0 never counts as a producer
    assign writesE = regWriteE_i & (destE_i != '0);
    assign writesM = regWriteM_i & (destM_i != '0);
    assign writesW = wb.valid & wb.regWrite & (wb.dest != '0);

    // load data only exists in writeback
    assign loadUse = (writesE & memReadE_i & (destE_i == rsD_i || destE_i == rtD_i)) |
                     (writesM & memReadM_i & (destM_i == rsD_i || destM_i == rtD_i));

    always_comb begin
        fwdA_o = fwdRegFile;
        fwdB_o = fwdRegFile;
        if (writesW && wb.dest == rsD_i) fwdA_o = fwdWb;  // oldest first so younger ones override
        if (writesM && destM_i == rsD_i) fwdA_o = fwdMem;
        if (writesE && destE_i == rsD_i) fwdA_o = fwdExe;
        if (writesW && wb.dest == rtD_i) fwdB_o = fwdWb;
        if (writesM && destM_i == rtD_i) fwdB_o = fwdMem;
        if (writesE && destE_i == rtD_i) fwdB_o = fwdExe;
    end

    assign stallFD_o = loadUse;
    assign bubbleE_o = loadUse;
    assign freeze_o  = dataStall_i;  // nothing moves while memory is busy

endmodule

//--- hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import mipsPkg::*; (
    input  aluOpE           op_i,
    input  logic [xlen-1:0] srcA_i,
    input  logic [xlen-1:0] srcB_i,
    output logic [xlen-1:0] result_o
);

    logic lessThan;

    assign lessThan = $signed(srcA_i) < $signed(srcB_i);

    always_comb begin
        case (op_i)
            aluAdd:  result_o = srcA_i + srcB_i;  // wraps with no overflow trap
            aluSub:  result_o = srcA_i - srcB_i;
            aluAnd:  result_o = srcA_i & srcB_i;
            aluOr:   result_o = srcA_i | srcB_i;
            aluXor:  result_o = srcA_i ^ srcB_i;
            aluSlt:  result_o = {{(xlen-1){1'b0}}, lessThan};
            aluLui:  result_o = {srcB_i[15:0], 16'b0};
            default: result_o = '0;
        endcase
    end

endmodule

//--- hdl/mipsDatapath.sv
`timescale 1ns/1ps

module mipsDatapath import mipsPkg::*; (
    input  logic                clk,
    input  logic                rstN_i,
    output logic                instEn_o,
    output logic [xlen-1:0]     instAddr_o,
    input  logic [xlen-1:0]     instData_i,
    output logic                dataEn_o,
    output logic [3:0]          dataWe_o,
    output logic [xlen-1:0]     dataAddr_o,
    output logic [xlen-1:0]     dataWdata_o,
    input  logic [xlen-1:0]     dataRdata_i,
    input  logic                dataStall_i,
    output logic [xlen-1:0]     debugWbPc_o,
    output logic [3:0]          debugWbRfWen_o,
    output logic [regAddrW-1:0] debugWbRfWnum_o,
    output logic [xlen-1:0]     debugWbRfWdata_o
);

    // fetch
    logic [xlen-1:0] pcF, pcNext;
    logic            fetchEn;
    // decode
    logic                validD, skidValid;
    logic [xlen-1:0]     pcD, skidInstr, instrD, immD, rdataA, rdataB, opA, opB;
    logic [xlen-1:0]     branchTarget;
    logic [regAddrW-1:0] destD;
    logic                branchTaken;
    ctrlS                ctrlD;
    // execute
    logic                validE;
    ctrlS                ctrlE;
    logic [xlen-1:0]     pcE, srcAE, srcBE, storeDataE, aluResultE;
    logic [regAddrW-1:0] destE;
    // memory
    logic                validM, regWriteM, memReadM, memWriteM;
    logic [xlen-1:0]     pcM, aluOutM, storeDataM;
    logic [regAddrW-1:0] destM;
    // writeback
    logic                validW, regWriteW, memReadW, rdataHeldValid;
    logic [xlen-1:0]     pcW, aluOutW, rdataHeld, loadData, wbData;
    logic [regAddrW-1:0] destW;
    // hazards
    fwdSelE fwdA, fwdB;
    logic   stallFD, bubbleE, freeze, holdD;

    wbIf wbBus ();

    function automatic logic [xlen-1:0] pickOperand(
        input fwdSelE          sel,
        input logic [xlen-1:0] rf,
        input logic [xlen-1:0] exe,
        input logic [xlen-1:0] mem,
        input logic [xlen-1:0] wb
    );
        case (sel)
            fwdExe:  return exe;
            fwdMem:  return mem;
            fwdWb:   return wb;
            default: return rf;
        endcase
    endfunction

    assign holdD      = stallFD | freeze;
    assign instEn_o   = fetchEn;
    assign instAddr_o = pcF;
    assign pcNext     = branchTaken ? branchTarget : pcF + 32'd4;

    // held word while decode waits and a no-op when nothing was fetched
    assign instrD = !validD ? '0 : (skidValid ? skidInstr : instData_i);

    mipsDecoder decoder_i (.instr_i(instrD), .ctrl_o(ctrlD));

    regFile regFile_i (
        .clk(clk), .rstN_i(rstN_i),
        .raddrA_i(instrD[25:21]), .raddrB_i(instrD[20:16]),
        .rdataA_o(rdataA), .rdataB_o(rdataB),
        .wb(wbBus)
    );

    assign immD  = ctrlD.signExt ? {{16{instrD[15]}}, instrD[15:0]} : {16'b0, instrD[15:0]};
    assign destD = ctrlD.destIsRt ? instrD[20:16] : instrD[15:11];
    assign opA   = pickOperand(fwdA, rdataA, aluResultE, aluOutM, wbData);
    assign opB   = pickOperand(fwdB, rdataB, aluResultE, aluOutM, wbData);

    assign branchTaken  = ctrlD.isBranch & ((opA == opB) ^ ctrlD.branchOnNe);
    assign branchTarget = pcD + 32'd4 + {immD[29:0], 2'b00};  // relative to delay slot

    hazardUnit hazard_i (
        .rsD_i(instrD[25:21]), .rtD_i(instrD[20:16]),
        .destE_i(destE), .regWriteE_i(validE & ctrlE.regWrite),
        .memReadE_i(validE & ctrlE.memRead),
        .destM_i(destM), .regWriteM_i(validM & regWriteM),
        .memReadM_i(validM & memReadM),
        .wb(wbBus), .dataStall_i(dataStall_i),
        .fwdA_o(fwdA), .fwdB_o(fwdB),
        .stallFD_o(stallFD), .bubbleE_o(bubbleE), .freeze_o(freeze)
    );

    aluUnit alu_i (.op_i(ctrlE.aluOp), .srcA_i(srcAE), .srcB_i(srcBE), .result_o(aluResultE));

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pcF            <= resetPc;
            fetchEn        <= 1'b0;
            validD         <= 1'b0;
            skidValid      <= 1'b0;
            validE         <= 1'b0;
            validM         <= 1'b0;
            validW         <= 1'b0;
            rdataHeldValid <= 1'b0;
        end else begin
            if (!freeze) begin
                fetchEn <= 1'b1;
                validE  <= validD & ctrlD.legal & ~bubbleE;  // bubble on load-use
                validM  <= validE;
                validW  <= validM;
            end
            if (!holdD) begin
                validD <= fetchEn;
                if (fetchEn) pcF <= pcNext;
            end
            skidValid      <= holdD;
            rdataHeldValid <= freeze;
        end
    end

    always_ff @(posedge clk) begin
        if (holdD && !skidValid) skidInstr <= instData_i;  // first stalled cycle
        if (freeze && !rdataHeldValid) rdataHeld <= dataRdata_i;
        if (!holdD) pcD <= pcF;
        if (!freeze) begin
            ctrlE      <= ctrlD;
            pcE        <= pcD;
            srcAE      <= opA;
            srcBE      <= ctrlD.useImm ? immD : opB;
            storeDataE <= opB;
            destE      <= destD;
            pcM        <= pcE;
            aluOutM    <= aluResultE;
            storeDataM <= storeDataE;
            destM      <= destE;
            regWriteM  <= ctrlE.regWrite;
            memReadM   <= ctrlE.memRead;
            memWriteM  <= ctrlE.memWrite;
            pcW        <= pcM;
            aluOutW    <= aluOutM;
            destW      <= destM;
            regWriteW  <= regWriteM;
            memReadW   <= memReadM;
        end
    end

    // memory stage request held steady by the freeze
    assign dataEn_o    = validM & (memReadM | memWriteM);
    assign dataWe_o    = {4{validM & memWriteM}};
    assign dataAddr_o  = aluOutM;
    assign dataWdata_o = storeDataM;

    assign loadData = rdataHeldValid ? rdataHeld : dataRdata_i;
    assign wbData   = memReadW ? loadData : aluOutW;

    assign wbBus.valid    = validW & ~freeze;  // commit only when the pipe moves
    assign wbBus.regWrite = regWriteW;
    assign wbBus.dest     = destW;
    assign wbBus.data     = wbData;
    assign wbBus.pc       = pcW;

    assign debugWbPc_o      = wbBus.pc;
    assign debugWbRfWen_o   = {4{wbBus.valid & wbBus.regWrite}};
    assign debugWbRfWnum_o  = wbBus.dest;
    assign debugWbRfWdata_o = wbBus.data;

endmodule

//--- include/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// progTab holds one instruction word per line by word index from resetPc
// wbTab columns are {pc, dest register, written value} in commit order
// storeTab columns are {byte address, stored word} in issue order

localparam int progLen  = 24;
localparam int wbLen    = 16;
localparam int storeLen = 3;

logic [31:0] progTab [0:progLen-1] = '{
    32'h3c018000,  // 00 lui   $1, 0x8000
    32'h34210010,  // 01 ori   $1, $1, 0x10
    32'h2402fffb,  // 02 addiu $2, $0, -5
    32'h0022182a,  // 03 slt   $3, $1, $2
    32'h00412023,  // 04 subu  $4, $2, $1
    32'h00822826,  // 05 xor   $5, $4, $2
    32'h00a13024,  // 06 and   $6, $5, $1
    32'h24070040,  // 07 addiu $7, $0, 0x40
    32'hace40000,  // 08 sw    $4, 0($7)
    32'h8ce80000,  // 09 lw    $8, 0($7)
    32'h25090001,  // 10 addiu $9, $8, 1 (load-use)
    32'hace90004,  // 11 sw    $9, 4($7)
    32'h01205021,  // 12 addu  $10, $9, $0
    32'h15480002,  // 13 bne   $10, $8, +2 (taken)
    32'h240b0007,  // 14 addiu $11, $0, 7 (delay slot)
    32'h240c0099,  // 15 skipped
    32'h116c0001,  // 16 beq   $11, $12, +1 (not taken)
    32'h016a6825,  // 17 or    $13, $11, $10 (delay slot)
    32'h11ad0002,  // 18 beq   $13, $13, +2 (taken)
    32'h8cee0004,  // 19 lw    $14, 4($7) (delay slot)
    32'h240f0055,  // 20 skipped
    32'hacee0008,  // 21 sw    $14, 8($7)
    32'h8cf00008,  // 22 lw    $16, 8($7)
    32'h02108821   // 23 addu  $17, $16, $16
};

logic [68:0] wbTab [0:wbLen-1] = '{
    {32'hbfc00000, 5'd1,  32'h80000000},
    {32'hbfc00004, 5'd1,  32'h80000010},
    {32'hbfc00008, 5'd2,  32'hfffffffb},
    {32'hbfc0000c, 5'd3,  32'h00000001},
    {32'hbfc00010, 5'd4,  32'h7fffffeb},
    {32'hbfc00014, 5'd5,  32'h80000010},
    {32'hbfc00018, 5'd6,  32'h80000010},
    {32'hbfc0001c, 5'd7,  32'h00000040},
    {32'hbfc00024, 5'd8,  32'h7fffffeb},
    {32'hbfc00028, 5'd9,  32'h7fffffec},
    {32'hbfc00030, 5'd10, 32'h7fffffec},
    {32'hbfc00038, 5'd11, 32'h00000007},
    {32'hbfc00044, 5'd13, 32'h7fffffef},
    {32'hbfc0004c, 5'd14, 32'h7fffffec},
    {32'hbfc00058, 5'd16, 32'h7fffffec},
    {32'hbfc0005c, 5'd17, 32'hffffffd8}
};

logic [63:0] storeTab [0:storeLen-1] = '{
    {32'h00000040, 32'h7fffffeb},
    {32'h00000044, 32'h7fffffec},
    {32'h00000048, 32'h7fffffec}
};

`endif

//--- verif/mipsDatapathTb.sv
`timescale 1ns/1ps

module mipsDatapathTb import mipsPkg::*; ();

    localparam int clkPeriod = 40;
    localparam int dmemWords = 64;

    `include "tbProgram.svh"

    logic            clk = 1'b0;
    logic            rstN_i, instEn_o, dataEn_o, dataStall_i;
    logic [xlen-1:0] instAddr_o, instData_i, dataAddr_o, dataWdata_o, dataRdata_i;
    logic [xlen-1:0] debugWbPc_o, debugWbRfWdata_o;
    logic [3:0]      dataWe_o, debugWbRfWen_o;
    logic [4:0]      debugWbRfWnum_o;
    logic [xlen-1:0] dmem [0:dmemWords-1];
    integer          seed = 32'hf0b6;
    int              errors = 0;
    int              checks = 0;
    int              wbIdx = 0;
    int              storeIdx = 0;

    mipsDatapath dut_i (.*);

    always #(clkPeriod/2) clk = ~clk;

    task automatic compareVal(input logic [31:0] got, input logic [31:0] expv, input string what);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expv);
        end
    endtask

    function automatic logic [31:0] fillWord(input int idx);
        return 32'hd00d0000 | (idx << 2);  // whole word address in the low half
    endfunction

    function automatic logic [31:0] romWord(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - resetPc) >> 2;
        return (idx < progLen) ? progTab[idx] : 32'h0;  // past the end reads as nop
    endfunction

    // synchronous instruction ROM
    always @(posedge clk) begin
        if (instEn_o) instData_i <= romWord(instAddr_o);
    end

    // data memory only acts on accepted cycles
    always @(posedge clk) begin
        if (dataEn_o && !dataStall_i) begin
            if (dataWe_o != 4'h0) dmem[dataAddr_o[7:2]] <= dataWdata_o;
            else dataRdata_i <= dmem[dataAddr_o[7:2]];
        end
    end

    always @(posedge clk) begin
        if (!rstN_i) dataStall_i <= 1'b0;
        else dataStall_i <= (($random(seed) & 3) == 0);  // about one cycle in four
    end

    // store monitor
    always @(negedge clk) begin
        if (rstN_i && dataEn_o && !dataStall_i && dataWe_o != 4'h0) begin
            compareVal(dataWe_o, 4'hf, "store byte enables");
            if (storeIdx < storeLen) begin
                compareVal(dataAddr_o, storeTab[storeIdx][63:32], "store address");
                compareVal(dataWdata_o, storeTab[storeIdx][31:0], "store data");
            end else begin
                errors++;
                $display("unexpected extra store to %h at %0t", dataAddr_o, $time);
            end
            storeIdx++;
        end
    end

    initial begin
        #((16 + (progLen + wbLen) * 20) * clkPeriod);
        $display("timeout: only %0d of %0d writebacks seen", wbIdx, wbLen);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] expWord;
        rstN_i      = 1'b0;
        dataStall_i = 1'b0;
        instData_i  = '0;
        dataRdata_i = '0;
        for (int i = 0; i < dmemWords; i++) dmem[i] = fillWord(i);
        @(posedge clk);
        repeat (15) begin
            @(negedge clk);
            compareVal(instEn_o, 1'b0, "instEn_o in reset");
            compareVal(dataEn_o, 1'b0, "dataEn_o in reset");
            compareVal(debugWbRfWen_o, 4'h0, "debugWbRfWen_o in reset");
            @(posedge clk);
        end
        rstN_i <= 1'b1;
        @(negedge clk);
        compareVal(instAddr_o, resetPc, "first fetch address");
        compareVal(instEn_o, 1'b0, "instEn_o after reset");
        compareVal(dataEn_o, 1'b0, "dataEn_o after reset");
        compareVal(dataWe_o, 4'h0, "dataWe_o after reset");
        compareVal(debugWbRfWen_o, 4'h0, "debugWbRfWen_o after reset");

        // step through the expected commits
        while (wbIdx < wbLen) begin
            @(negedge clk);
            if (debugWbRfWen_o != 4'h0) begin
                compareVal(debugWbRfWen_o, 4'hf, "writeback enables");
                compareVal(debugWbPc_o, wbTab[wbIdx][68:37], "writeback pc");
                compareVal(debugWbRfWnum_o, wbTab[wbIdx][36:32], "writeback register");
                compareVal(debugWbRfWdata_o, wbTab[wbIdx][31:0], "writeback data");
                wbIdx++;
            end
        end

        compareVal(storeIdx, storeLen, "number of stores");
        for (int i = 0; i < dmemWords; i++) begin
            expWord = fillWord(i);
            for (int s = 0; s < storeLen; s++) begin
                if (storeTab[s][63:32] == (i << 2)) expWord = storeTab[s][31:0];
            end
            compareVal(dmem[i], expWord, $sformatf("final dmem word %0d", i));
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+include
hdl/mipsPkg.sv
hdl/wbIf.sv
hdl/mipsDecoder.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/aluUnit.sv
hdl/mipsDatapath.sv
verif/mipsDatapathTb.sv

//--- Bender.yml
package:
  name: mips_datapath

sources:
  - files:
      - hdl/mipsPkg.sv
      - hdl/wbIf.sv
      - hdl/mipsDecoder.sv
      - hdl/regFile.sv
      - hdl/hazardUnit.sv
      - hdl/aluUnit.sv
      - hdl/mipsDatapath.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/mipsDatapathTb.sv
